/* include/backend_params.svh */
`ifndef BACKEND_PARAMS_SVH
`define BACKEND_PARAMS_SVH

`define BE_XLEN      32
`define BE_ARCH_REGS 8
`define BE_PHYS_REGS 16
`define BE_ROB_DEPTH 8
`define BE_RS_DEPTH  4
`define BE_IQ_DEPTH  4

`endif

/* hw/backend_pkg.sv */
`include "backend_params.svh"

package backend_pkg;

    typedef logic [$clog2(`BE_ARCH_REGS)-1:0] arch_reg_t;
    typedef logic [$clog2(`BE_PHYS_REGS)-1:0] phys_reg_t;
    typedef logic [$clog2(`BE_ROB_DEPTH)-1:0] rob_id_t;
    typedef logic [`BE_XLEN-1:0]              data_t;

    typedef enum logic [2:0] {
        op_add,
        op_sub,
        op_and,
        op_xor,
        op_addi
    } alu_op_e;

    typedef struct packed {
        alu_op_e     op;
        arch_reg_t   rd;
        arch_reg_t   rs1;
        arch_reg_t   rs2;
        logic [15:0] imm;   // sign-extended by the ALU
    } inst_t;

    typedef struct packed {
        alu_op_e     op;
        logic [15:0] imm;
        rob_id_t     rob_id;
        phys_reg_t   prd;
        phys_reg_t   prs1;
        phys_reg_t   prs2;
        logic        rs1_ready;
        logic        rs2_ready;
    } rs_entry_t;

    typedef struct packed {
        arch_reg_t rd;
        phys_reg_t prd;
        rob_id_t   rob_id;
    } rob_alloc_t;

    typedef struct packed {
        logic      valid;
        rob_id_t   rob_id;
        phys_reg_t prd;
        data_t     value;
    } cdb_t;

    typedef struct packed {
        logic      valid;
        arch_reg_t rd;
        data_t     value;
    } commit_t;

endpackage

/* hw/circ_queue.sv */
`timescale 1ns/100ps

module circ_queue #(
    parameter int unsigned DEPTH     = 4,
    parameter type         payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     push_i,
    input  payload_t push_data_i,
    input  logic     pop_i,
    output payload_t pop_data_o,
    output logic     empty_o,
    output logic     full_o
);

    localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int unsigned CNT_W = $clog2(DEPTH + 1);

    payload_t         mem_q [DEPTH];
    logic [PTR_W-1:0] rd_ptr_q;
    logic [PTR_W-1:0] wr_ptr_q;
    logic [CNT_W-1:0] count_q;
    logic [CNT_W-1:0] count_d;
    logic             full_q;
    logic             do_push;
    logic             do_pop;

    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign do_push    = push_i & ~full_q;
    assign do_pop     = pop_i & ~empty_o;
    assign count_d    = count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    assign empty_o    = (count_q == '0);
    assign full_o     = full_q;
    assign pop_data_o = mem_q[rd_ptr_q];   // show-ahead head

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
            full_q   <= 1'b1;   // reads full for the first cycle out of reset
        end else begin
            if (do_push) begin
                wr_ptr_q <= ptr_inc(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= ptr_inc(rd_ptr_q);
            end
            count_q <= count_d;
            full_q  <= (count_d == CNT_W'(DEPTH));
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_q[wr_ptr_q] <= push_data_i;
        end
    end

endmodule

/* hw/prf.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module prf (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  backend_pkg::phys_reg_t rs1_i,
    input  backend_pkg::phys_reg_t rs2_i,
    output backend_pkg::data_t     rs1_value_o,
    output backend_pkg::data_t     rs2_value_o,
    input  backend_pkg::phys_reg_t ready_q1_i,
    input  backend_pkg::phys_reg_t ready_q2_i,
    output logic                   ready_q1_o,
    output logic                   ready_q2_o,
    input  backend_pkg::phys_reg_t clear_i,
    input  logic                   clear_valid_i,
    input  backend_pkg::cdb_t      cdb_i
);

    import backend_pkg::*;

    data_t                    value_q [`BE_PHYS_REGS];
    logic [`BE_PHYS_REGS-1:0] ready_q;

    // same-cycle CDB write is forwarded on every lookup
    assign rs1_value_o = (cdb_i.valid && cdb_i.prd == rs1_i) ? cdb_i.value : value_q[rs1_i];
    assign rs2_value_o = (cdb_i.valid && cdb_i.prd == rs2_i) ? cdb_i.value : value_q[rs2_i];
    assign ready_q1_o  = ready_q[ready_q1_i] | (cdb_i.valid && cdb_i.prd == ready_q1_i);
    assign ready_q2_o  = ready_q[ready_q2_i] | (cdb_i.valid && cdb_i.prd == ready_q2_i);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            ready_q <= '1;
            for (int i = 0; i < `BE_PHYS_REGS; i++) begin
                value_q[i] <= '0;   // architectural state starts at zero
            end
        end else begin
            if (clear_valid_i) begin
                ready_q[clear_i] <= 1'b0;
            end
            if (cdb_i.valid) begin
                ready_q[cdb_i.prd] <= 1'b1;
                value_q[cdb_i.prd] <= cdb_i.value;
            end
        end
    end

endmodule

/* hw/int_rs.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module int_rs (
    input  logic                   clk,
    input  logic                   arst_n_i,
    input  backend_pkg::rs_entry_t entry_i,
    input  logic                   dispatch_i,
    output logic                   full_o,
    output backend_pkg::phys_reg_t prf_rs1_o,
    output backend_pkg::phys_reg_t prf_rs2_o,
    input  backend_pkg::data_t     rs1_value_i,
    input  backend_pkg::data_t     rs2_value_i,
    output backend_pkg::cdb_t      cdb_o
);

    import backend_pkg::*;

    localparam int unsigned N     = `BE_RS_DEPTH;
    localparam int unsigned IDX_W = $clog2(N);

    rs_entry_t        ent_q [N];
    logic [IDX_W-1:0] age_q [N];   // 0 is youngest
    logic [N-1:0]     valid_q;
    logic [N-1:0]     rdy1;
    logic [N-1:0]     rdy2;
    logic             issue;
    logic [IDX_W-1:0] issue_idx;
    logic [IDX_W-1:0] free_idx;
    rs_entry_t        sel;
    data_t            opnd_b;
    data_t            result;
    cdb_t             cdb_q;

    assign full_o    = &valid_q;
    assign cdb_o     = cdb_q;
    assign sel       = ent_q[issue_idx];
    assign prf_rs1_o = sel.prs1;
    assign prf_rs2_o = sel.prs2;

    // result on the bus this cycle counts as ready
    always_comb begin
        for (int i = 0; i < N; i++) begin
            rdy1[i] = ent_q[i].rs1_ready | (cdb_q.valid && cdb_q.prd == ent_q[i].prs1);
            rdy2[i] = ent_q[i].rs2_ready | (cdb_q.valid && cdb_q.prd == ent_q[i].prs2);
        end
    end

    always_comb begin
        issue     = 1'b0;
        issue_idx = '0;
        free_idx  = '0;
        for (int i = 0; i < N; i++) begin
            if (valid_q[i] && rdy1[i] && rdy2[i] && (!issue || age_q[i] > age_q[issue_idx])) begin
                issue     = 1'b1;
                issue_idx = IDX_W'(i);
            end
        end
        for (int i = N - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                free_idx = IDX_W'(i);
            end
        end
    end

    assign opnd_b = (sel.op == op_addi) ? {{(`BE_XLEN-16){sel.imm[15]}}, sel.imm} : rs2_value_i;

    always_comb begin
        case (sel.op)
            op_sub:  result = rs1_value_i - opnd_b;
            op_and:  result = rs1_value_i & opnd_b;
            op_xor:  result = rs1_value_i ^ opnd_b;
            default: result = rs1_value_i + opnd_b;   // add, addi
        endcase
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q <= '0;
            cdb_q   <= '0;
            for (int i = 0; i < N; i++) begin
                age_q[i] <= '0;
            end
        end else begin
            // ages stay a compact 0..count-1 ordering
            for (int i = 0; i < N; i++) begin
                age_q[i] <= age_q[i] + IDX_W'(dispatch_i)
                          - IDX_W'(issue && age_q[i] > age_q[issue_idx]);
            end
            if (issue) begin
                valid_q[issue_idx] <= 1'b0;
            end
            if (dispatch_i) begin
                valid_q[free_idx] <= 1'b1;
                age_q[free_idx]   <= '0;
            end
            cdb_q.valid  <= issue;
            cdb_q.rob_id <= sel.rob_id;
            cdb_q.prd    <= sel.prd;
            cdb_q.value  <= result;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            ent_q[i].rs1_ready <= rdy1[i];
            ent_q[i].rs2_ready <= rdy2[i];
        end
        if (dispatch_i) begin
            ent_q[free_idx] <= entry_i;
        end
    end

endmodule

/* hw/rob.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module rob (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  backend_pkg::rob_alloc_t alloc_i,
    input  logic                    alloc_valid_i,
    output backend_pkg::rob_id_t    alloc_id_o,
    output logic                    full_o,
    input  backend_pkg::cdb_t       cdb_i,
    output backend_pkg::commit_t    commit_o,
    output backend_pkg::phys_reg_t  free_reg_o,
    output logic                    free_reg_valid_o
);

    import backend_pkg::*;

    localparam int unsigned CNT_W = $clog2(`BE_ROB_DEPTH + 1);

    logic [`BE_ROB_DEPTH-1:0] busy_q;
    logic [`BE_ROB_DEPTH-1:0] done_q;
    arch_reg_t                rd_q    [`BE_ROB_DEPTH];
    phys_reg_t                prd_q   [`BE_ROB_DEPTH];
    data_t                    value_q [`BE_ROB_DEPTH];
    phys_reg_t                rrat_q  [`BE_ARCH_REGS];   // retirement map
    rob_id_t                  head_q;
    rob_id_t                  tail_q;
    logic [CNT_W-1:0]         count_q;
    logic                     commit_fire;

    assign alloc_id_o  = tail_q;
    assign full_o      = (count_q == CNT_W'(`BE_ROB_DEPTH));
    assign commit_fire = busy_q[head_q] & done_q[head_q];

    assign commit_o = '{valid: commit_fire, rd: rd_q[head_q], value: value_q[head_q]};

    // the mapping being replaced goes back to the free list
    assign free_reg_o       = rrat_q[rd_q[head_q]];
    assign free_reg_valid_o = commit_fire;

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q  <= '0;
            done_q  <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            for (int i = 0; i < `BE_ARCH_REGS; i++) begin
                rrat_q[i] <= phys_reg_t'(i);
            end
        end else begin
            if (alloc_valid_i) begin
                busy_q[alloc_i.rob_id] <= 1'b1;
                done_q[alloc_i.rob_id] <= 1'b0;
                tail_q                 <= tail_q + 1'b1;
            end
            if (cdb_i.valid) begin
                done_q[cdb_i.rob_id] <= 1'b1;
            end
            if (commit_fire) begin
                busy_q[head_q]         <= 1'b0;
                head_q                 <= head_q + 1'b1;
                rrat_q[rd_q[head_q]]   <= prd_q[head_q];
            end
            count_q <= count_q + CNT_W'(alloc_valid_i) - CNT_W'(commit_fire);
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_valid_i) begin
            rd_q[alloc_i.rob_id]  <= alloc_i.rd;
            prd_q[alloc_i.rob_id] <= alloc_i.prd;
        end
        if (cdb_i.valid) begin
            value_q[cdb_i.rob_id] <= cdb_i.value;
        end
    end

endmodule

/* hw/rename_stage.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module rename_stage (
    input  logic                    clk,
    input  logic                    arst_n_i,
    input  backend_pkg::inst_t      inst_i,
    input  logic                    inst_avail_i,
    output logic                    inst_pop_o,
    output backend_pkg::rob_alloc_t rob_alloc_o,
    output logic                    rob_alloc_valid_o,
    input  backend_pkg::rob_id_t    rob_id_i,
    input  logic                    rob_full_i,
    output backend_pkg::rs_entry_t  rs_entry_o,
    output logic                    rs_dispatch_o,
    input  logic                    rs_full_i,
    output backend_pkg::phys_reg_t  prf_rs1_o,
    output backend_pkg::phys_reg_t  prf_rs2_o,
    input  logic                    prf_rs1_ready_i,
    input  logic                    prf_rs2_ready_i,
    output backend_pkg::phys_reg_t  prf_clear_o,
    output logic                    prf_clear_valid_o,
    input  backend_pkg::phys_reg_t  free_reg_i,
    input  logic                    free_reg_valid_i
);

    import backend_pkg::*;

    localparam int unsigned FREE_REGS = `BE_PHYS_REGS - `BE_ARCH_REGS;
    localparam int unsigned FILL_W    = $clog2(FREE_REGS + 1);

    phys_reg_t         rat_q [`BE_ARCH_REGS];
    logic [FILL_W-1:0] fill_cnt_q;
    logic              fill_busy;
    logic              fl_push;
    logic              fl_empty;
    logic              fl_full;
    phys_reg_t         fl_push_reg;
    phys_reg_t         fl_head;
    logic              dispatch;

    // free list seeded with the registers not in the initial map
    assign fill_busy   = (fill_cnt_q != FILL_W'(FREE_REGS));
    assign fl_push     = fill_busy | free_reg_valid_i;
    assign fl_push_reg = fill_busy ? phys_reg_t'(`BE_ARCH_REGS + fill_cnt_q) : free_reg_i;

    circ_queue #(
        .DEPTH     (FREE_REGS),
        .payload_t (phys_reg_t)
    ) i_free_list (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .push_i      (fl_push),
        .push_data_i (fl_push_reg),
        .pop_i       (dispatch),
        .pop_data_o  (fl_head),
        .empty_o     (fl_empty),
        .full_o      (fl_full)
    );

    assign dispatch = inst_avail_i & ~fl_empty & ~rob_full_i & ~rs_full_i & ~fill_busy;

    assign inst_pop_o        = dispatch;
    assign rob_alloc_valid_o = dispatch;
    assign rs_dispatch_o     = dispatch;
    assign prf_clear_valid_o = dispatch;
    assign prf_clear_o       = fl_head;
    assign prf_rs1_o         = rat_q[inst_i.rs1];
    assign prf_rs2_o         = rat_q[inst_i.rs2];

    assign rob_alloc_o = '{rd: inst_i.rd, prd: fl_head, rob_id: rob_id_i};

    always_comb begin
        rs_entry_o.op        = inst_i.op;
        rs_entry_o.imm       = inst_i.imm;
        rs_entry_o.rob_id    = rob_id_i;
        rs_entry_o.prd       = fl_head;
        rs_entry_o.prs1      = prf_rs1_o;
        rs_entry_o.prs2      = prf_rs2_o;
        rs_entry_o.rs1_ready = prf_rs1_ready_i;
        rs_entry_o.rs2_ready = prf_rs2_ready_i | (inst_i.op == op_addi);   // addi has no rs2
    end

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fill_cnt_q <= '0;
            for (int i = 0; i < `BE_ARCH_REGS; i++) begin
                rat_q[i] <= phys_reg_t'(i);
            end
        end else begin
            if (fill_busy && !fl_full) begin
                fill_cnt_q <= fill_cnt_q + 1'b1;
            end
            if (dispatch) begin
                rat_q[inst_i.rd] <= fl_head;
            end
        end
    end

endmodule

/* hw/backend_top.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module backend_top (
    input  logic                 clk,
    input  logic                 arst_n_i,
    input  logic                 instr_valid_i,
    input  backend_pkg::inst_t   instr_i,
    output logic                 instr_ready_o,
    output backend_pkg::commit_t commit_o
);

    import backend_pkg::*;

    inst_t      iq_inst;
    logic       iq_empty;
    logic       iq_full;
    logic       iq_pop;
    rob_alloc_t rob_alloc;
    logic       rob_alloc_valid;
    rob_id_t    rob_id;
    logic       rob_full;
    rs_entry_t  rs_entry;
    logic       rs_dispatch;
    logic       rs_full;
    phys_reg_t  ren_rs1;
    phys_reg_t  ren_rs2;
    logic       ren_rs1_ready;
    logic       ren_rs2_ready;
    phys_reg_t  iss_rs1;
    phys_reg_t  iss_rs2;
    data_t      rs1_value;
    data_t      rs2_value;
    phys_reg_t  clear_reg;
    logic       clear_valid;
    phys_reg_t  free_reg;
    logic       free_reg_valid;
    cdb_t       cdb;

    assign instr_ready_o = ~iq_full;

    circ_queue #(
        .DEPTH     (`BE_IQ_DEPTH),
        .payload_t (inst_t)
    ) i_inst_queue (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .push_i      (instr_valid_i),
        .push_data_i (instr_i),
        .pop_i       (iq_pop),
        .pop_data_o  (iq_inst),
        .empty_o     (iq_empty),
        .full_o      (iq_full)
    );

    rename_stage i_rename (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .inst_i            (iq_inst),
        .inst_avail_i      (!iq_empty),
        .inst_pop_o        (iq_pop),
        .rob_alloc_o       (rob_alloc),
        .rob_alloc_valid_o (rob_alloc_valid),
        .rob_id_i          (rob_id),
        .rob_full_i        (rob_full),
        .rs_entry_o        (rs_entry),
        .rs_dispatch_o     (rs_dispatch),
        .rs_full_i         (rs_full),
        .prf_rs1_o         (ren_rs1),
        .prf_rs2_o         (ren_rs2),
        .prf_rs1_ready_i   (ren_rs1_ready),
        .prf_rs2_ready_i   (ren_rs2_ready),
        .prf_clear_o       (clear_reg),
        .prf_clear_valid_o (clear_valid),
        .free_reg_i        (free_reg),
        .free_reg_valid_i  (free_reg_valid)
    );

    rob i_rob (
        .clk              (clk),
        .arst_n_i         (arst_n_i),
        .alloc_i          (rob_alloc),
        .alloc_valid_i    (rob_alloc_valid),
        .alloc_id_o       (rob_id),
        .full_o           (rob_full),
        .cdb_i            (cdb),
        .commit_o         (commit_o),
        .free_reg_o       (free_reg),
        .free_reg_valid_o (free_reg_valid)
    );

    int_rs i_int_rs (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .entry_i     (rs_entry),
        .dispatch_i  (rs_dispatch),
        .full_o      (rs_full),
        .prf_rs1_o   (iss_rs1),
        .prf_rs2_o   (iss_rs2),
        .rs1_value_i (rs1_value),
        .rs2_value_i (rs2_value),
        .cdb_o       (cdb)
    );

    prf i_prf (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .rs1_i         (iss_rs1),
        .rs2_i         (iss_rs2),
        .rs1_value_o   (rs1_value),
        .rs2_value_o   (rs2_value),
        .ready_q1_i    (ren_rs1),
        .ready_q2_i    (ren_rs2),
        .ready_q1_o    (ren_rs1_ready),
        .ready_q2_o    (ren_rs2_ready),
        .clear_i       (clear_reg),
        .clear_valid_i (clear_valid),
        .cdb_i         (cdb)
    );

endmodule

/* tests/backend_properties.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module backend_properties (
    input logic                     clk,
    input logic                     arst_n_i,
    input logic [`BE_ROB_DEPTH-1:0] busy_i,
    input logic [`BE_ROB_DEPTH-1:0] done_i,
    input backend_pkg::rob_id_t     head_i,
    input backend_pkg::cdb_t        cdb_i,
    input backend_pkg::commit_t     commit_i
);

    int unsigned assert_fail_cnt = 0;   // read by the testbench at the end

    // a result may only land in a slot that is still waiting for it
    cdb_to_busy_slot: assert property (@(posedge clk) disable iff (!arst_n_i)
        cdb_i.valid |-> (busy_i[cdb_i.rob_id] && !done_i[cdb_i.rob_id]))
    else begin
        assert_fail_cnt++;
        $error("CDB write to rob slot %0d which is not waiting for a result", cdb_i.rob_id);
    end

    // the head must have finished before the cycle it retires in
    commit_done_head: assert property (@(posedge clk) disable iff (!arst_n_i)
        commit_i.valid |-> !(cdb_i.valid && cdb_i.rob_id == head_i))
    else begin
        assert_fail_cnt++;
        $error("commit from rob slot %0d in the cycle its result arrives", head_i);
    end

    no_commit_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !commit_i.valid)
    else begin
        assert_fail_cnt++;
        $error("commit valid while reset is asserted");
    end

endmodule

bind rob backend_properties i_props (
    .clk      (clk),
    .arst_n_i (arst_n_i),
    .busy_i   (busy_q),
    .done_i   (done_q),
    .head_i   (head_q),
    .cdb_i    (cdb_i),
    .commit_i (commit_o)
);

/* tests/backend_tb.sv */
`timescale 1ns/100ps
`include "backend_params.svh"

module backend_tb;

    import backend_pkg::*;

    localparam int NUM_INSTR   = 300;
    localparam int BURST_END   = 60;    // no gaps before this, runs into the fill stall
    localparam int CHAIN_START = 200;   // regs 0 and 1 only from here on
    localparam int CYCLE_LIMIT = NUM_INSTR * 20 + 200;

    logic    clk;
    logic    arst_n_i;
    logic    instr_valid_i;
    inst_t   instr_i;
    logic    instr_ready_o;
    commit_t commit_o;

    data_t   arch_regs [`BE_ARCH_REGS];   // in-order reference state
    commit_t exp_q [$];
    int      seed;
    int      err_cnt      = 0;
    int      check_cnt    = 0;
    int      accepted     = 0;
    int      committed    = 0;
    int      stall_cycles = 0;
    int      cycles       = 0;

    backend_top i_dut (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .instr_ready_o (instr_ready_o),
        .commit_o      (commit_o)
    );

    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
        end
    endtask

    function automatic commit_t model_exec(input inst_t inst);
        data_t   a;
        data_t   b;
        data_t   res;
        commit_t c;
        a = arch_regs[inst.rs1];
        if (inst.op == op_addi) begin
            b = data_t'($signed(inst.imm));
        end else begin
            b = arch_regs[inst.rs2];
        end
        case (inst.op)
            op_add, op_addi: res = a + b;
            op_sub:          res = a - b;
            op_and:          res = a & b;
            op_xor:          res = a ^ b;
            default:         res = '0;
        endcase
        arch_regs[inst.rd] = res;
        c.valid = 1'b1;
        c.rd    = inst.rd;
        c.value = res;
        return c;
    endfunction

    function automatic inst_t random_inst();
        inst_t inst;
        inst.op  = alu_op_e'(3'($unsigned($random(seed)) % 5));
        inst.rd  = arch_reg_t'($random(seed));
        inst.rs1 = arch_reg_t'($random(seed));
        inst.rs2 = arch_reg_t'($random(seed));
        inst.imm = 16'($random(seed));
        return inst;
    endfunction

    // holds the instruction until the queue takes it
    task automatic send_inst(input inst_t inst);
        @(negedge clk);
        instr_valid_i = 1'b1;
        instr_i       = inst;
        while (!instr_ready_o) begin
            stall_cycles++;
            @(negedge clk);
        end
        accepted++;
        exp_q.push_back(model_exec(inst));
    endtask

    task automatic finish_run();
        int total;
        total = err_cnt + i_dut.i_rob.i_props.assert_fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d, accepted %0d, committed %0d",
                 check_cnt, err_cnt, i_dut.i_rob.i_props.assert_fail_cnt, accepted, committed);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    // commit_o is driven from rob registers and sampled mid-cycle
    always @(negedge clk) begin
        commit_t exp;
        if (!arst_n_i) begin
            check_value("commit_o.valid", 32'(commit_o.valid), 32'h0);
        end else if (commit_o.valid) begin
            committed++;
            if (exp_q.size() == 0) begin
                err_cnt++;
                $display("commit to r%0d arrived with no instruction outstanding", commit_o.rd);
            end else begin
                exp = exp_q.pop_front();
                check_value("commit_o.rd", 32'(commit_o.rd), 32'(exp.rd));
                check_value("commit_o.value", commit_o.value, exp.value);
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            err_cnt++;
            $display("run stopped after %0d cycles with %0d commits still missing",
                     cycles, exp_q.size());
            finish_run();
        end
    end

    initial begin
        inst_t     inst;
        arch_reg_t prev_rd;
        int        gap;
        seed          = 32'h0968ab35;
        clk           = 1'b0;
        arst_n_i      = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        prev_rd       = '0;
        for (int r = 0; r < `BE_ARCH_REGS; r++) begin
            arch_regs[r] = '0;
        end
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n_i = 1'b1;

        for (int i = 0; i < NUM_INSTR; i++) begin
            inst = random_inst();
            if (i >= CHAIN_START) begin
                inst.rs1 = prev_rd;   // always reads the result just before it
                inst.rs2 = arch_reg_t'(inst.rs2[0]);
                inst.rd  = arch_reg_t'(inst.rd[0]);
            end
            send_inst(inst);
            prev_rd = inst.rd;
            if (i >= BURST_END && i < CHAIN_START) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) begin
                    @(negedge clk);
                    instr_valid_i = 1'b0;
                end
            end
        end
        @(negedge clk);
        instr_valid_i = 1'b0;

        while (exp_q.size() != 0) begin
            @(negedge clk);
        end
        repeat (20) @(negedge clk);   // any commit here is flagged by the monitor
        check_value("commit count", 32'(committed), 32'(accepted));
        if (stall_cycles == 0) begin
            err_cnt++;
            $display("instr_ready_o never dropped while instructions were offered");
        end
        finish_run();
    end

endmodule

/* backend_top.f */
+incdir+include
hw/backend_pkg.sv
hw/circ_queue.sv
hw/prf.sv
hw/int_rs.sv
hw/rob.sv
hw/rename_stage.sv
hw/backend_top.sv
tests/backend_properties.sv
tests/backend_tb.sv

/* Bender.yml */
package:
  name: backend_top

sources:
  - include_dirs:
      - include
    files:
      - hw/backend_pkg.sv
      - hw/circ_queue.sv
      - hw/prf.sv
      - hw/int_rs.sv
      - hw/rob.sv
      - hw/rename_stage.sv
      - hw/backend_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tests/backend_properties.sv
      - tests/backend_tb.sv
